// ==== Makefile ====
# Verilator flow for the register side

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module scariv_regs_top

sim:
	verilator --binary --timing -f verilog.f --top-module scariv_regs_tb
	@out=$$(./obj_dir/Vscariv_regs_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== hw/scariv_phy_registers.sv ====
// Physical register file
// Accepts only writebacks of its own register type, highest port wins on a
// collision, reads are registered with same-edge write bypass
// Integer file keeps register 0 at zero

`include "scariv_macros.svh"

module scariv_phy_registers
  import scariv_reg_pkg::*;
  import scariv_port_pkg::*;
#(
  parameter reg_type_t REG_TYPE = GPR
) (
  input  logic      i_clk,
  input  logic      i_rst_n,

  // Writeback from execution ports
  input  wr_mask_t  i_wr_valid,
  input  reg_type_t i_wr_type [`SCARIV_WR_PORTS],
  input  rnid_t     i_wr_rnid [`SCARIV_WR_PORTS],
  input  reg_data_t i_wr_data [`SCARIV_WR_PORTS],

  // Read ports
  input  rnid_t     i_rd_rnid [`SCARIV_RD_PORTS],
  output reg_data_t o_rd_data [`SCARIV_RD_PORTS]
);

  localparam int REG_NUM = 1 << `SCARIV_RNID_W;

  wr_mask_t  w_wr_accept;
  reg_data_t r_regs      [REG_NUM];
  logic      w_reg_we    [REG_NUM];
  reg_data_t w_reg_wdata [REG_NUM];  // Next value, equals r_regs when idle
  reg_data_t r_rd_data   [`SCARIV_RD_PORTS];

  // --------------------
  // Write filter
  // --------------------
  always_comb begin
    for (int p = 0; p < `SCARIV_WR_PORTS; p++) begin
      w_wr_accept[p] = i_wr_valid[p] & (i_wr_type[p] == REG_TYPE);
      // x0 is hardwired in the integer file
      if ((REG_TYPE == GPR) && (i_wr_rnid[p] == '0)) begin
        w_wr_accept[p] = 1'b0;
      end
    end
  end

  // Per register merge, later port overrides earlier
  always_comb begin
    for (int r = 0; r < REG_NUM; r++) begin
      w_reg_we[r]    = 1'b0;
      w_reg_wdata[r] = r_regs[r];
      for (int p = 0; p < `SCARIV_WR_PORTS; p++) begin
        if (w_wr_accept[p] && (i_wr_rnid[p] == rnid_t'(r))) begin
          w_reg_we[r]    = 1'b1;
          w_reg_wdata[r] = i_wr_data[p];
        end
      end
    end
  end

  // --------------------
  // Register array
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int r = 0; r < REG_NUM; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int r = 0; r < REG_NUM; r++) begin
        if (w_reg_we[r]) begin
          r_regs[r] <= w_reg_wdata[r];
        end
      end
    end
  end

  // --------------------
  // Read ports
  // --------------------
  // Sampling the merged next value gives the bypass for free
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < `SCARIV_RD_PORTS; p++) begin
      r_rd_data[p] <= w_reg_wdata[i_rd_rnid[p]];
    end
  end

  always_comb begin
    for (int p = 0; p < `SCARIV_RD_PORTS; p++) begin
      o_rd_data[p] = r_rd_data[p];
    end
  end

endmodule

// ==== hw/scariv_port_pkg.sv ====
// Port group types
// One strobe bit per writeback port and per read port

`include "scariv_macros.svh"

package scariv_port_pkg;

  // Writeback valid strobes, indexed by port
  typedef logic [`SCARIV_WR_PORTS-1:0] wr_mask_t;

  // Read request valid strobes
  typedef logic [`SCARIV_RD_PORTS-1:0] rd_mask_t;

endpackage

// ==== hw/scariv_reg_pkg.sv ====
// Register types
// Register file kind, physical register number and data word

`include "scariv_macros.svh"

package scariv_reg_pkg;

  // Which physical file a register number lives in
  typedef enum logic [0:0] {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_type_t;

  // Physical register number
  typedef logic [`SCARIV_RNID_W-1:0] rnid_t;

  // One register word
  typedef logic [`SCARIV_XLEN-1:0] reg_data_t;

endpackage

// ==== hw/scariv_regread_merge.sv ====
// Register read merge
// Delays read valid and type by one cycle to line up with the file data,
// then picks the integer or FP word per port

`include "scariv_macros.svh"

module scariv_regread_merge
  import scariv_reg_pkg::*;
  import scariv_port_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,

  // Read requests, same cycle as the file address
  input  rd_mask_t  i_rd_valid,
  input  reg_type_t i_rd_type [`SCARIV_RD_PORTS],

  // Registered data from both files
  input  reg_data_t i_int_rd_data [`SCARIV_RD_PORTS],
  input  reg_data_t i_fp_rd_data  [`SCARIV_RD_PORTS],

  output rd_mask_t  o_rd_valid,
  output reg_data_t o_rd_data [`SCARIV_RD_PORTS]
);

  rd_mask_t  r_rd_valid;
  reg_type_t r_rd_type [`SCARIV_RD_PORTS];

  // --------------------
  // Request stage
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_rd_valid <= '0;
      for (int p = 0; p < `SCARIV_RD_PORTS; p++) begin
        r_rd_type[p] <= GPR;
      end
    end else begin
      r_rd_valid <= i_rd_valid;
      for (int p = 0; p < `SCARIV_RD_PORTS; p++) begin
        r_rd_type[p] <= i_rd_type[p];
      end
    end
  end

  assign o_rd_valid = r_rd_valid;

  // Data is don't-care on ports that are not valid
  always_comb begin
    for (int p = 0; p < `SCARIV_RD_PORTS; p++) begin
      if (r_rd_type[p] == FPR) begin
        o_rd_data[p] = i_fp_rd_data[p];
      end else begin
        o_rd_data[p] = i_int_rd_data[p];
      end
    end
  end

endmodule

// ==== hw/scariv_regs_top.sv ====
// Register side of the tile
// Writeback ports feed both physical files, reads come back one cycle later
// through the merge stage

`include "scariv_macros.svh"

module scariv_regs_top
  import scariv_reg_pkg::*;
  import scariv_port_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,

  // Writeback ports
  input  wr_mask_t  i_wr_valid,
  input  reg_type_t i_wr_type [`SCARIV_WR_PORTS],
  input  rnid_t     i_wr_rnid [`SCARIV_WR_PORTS],
  input  reg_data_t i_wr_data [`SCARIV_WR_PORTS],

  // Read ports
  input  rd_mask_t  i_rd_valid,
  input  reg_type_t i_rd_type [`SCARIV_RD_PORTS],
  input  rnid_t     i_rd_rnid [`SCARIV_RD_PORTS],

  output rd_mask_t  o_rd_valid,
  output reg_data_t o_rd_data [`SCARIV_RD_PORTS]
);

  wr_mask_t  w_wr_valid;
  reg_type_t w_wr_type [`SCARIV_WR_PORTS];
  rnid_t     w_wr_rnid [`SCARIV_WR_PORTS];
  reg_data_t w_wr_data [`SCARIV_WR_PORTS];

  reg_data_t w_int_rd_data [`SCARIV_RD_PORTS];
  reg_data_t w_fp_rd_data  [`SCARIV_RD_PORTS];

  // --------------------
  // Writeback bus
  // --------------------
  // ALU
  assign w_wr_valid[`SCARIV_ALU_WR_PORT] = i_wr_valid[`SCARIV_ALU_WR_PORT];
  assign w_wr_type [`SCARIV_ALU_WR_PORT] = i_wr_type [`SCARIV_ALU_WR_PORT];
  assign w_wr_rnid [`SCARIV_ALU_WR_PORT] = i_wr_rnid [`SCARIV_ALU_WR_PORT];
  assign w_wr_data [`SCARIV_ALU_WR_PORT] = i_wr_data [`SCARIV_ALU_WR_PORT];

  // LSU, loads to either file
  assign w_wr_valid[`SCARIV_LSU_WR_PORT] = i_wr_valid[`SCARIV_LSU_WR_PORT];
  assign w_wr_type [`SCARIV_LSU_WR_PORT] = i_wr_type [`SCARIV_LSU_WR_PORT];
  assign w_wr_rnid [`SCARIV_LSU_WR_PORT] = i_wr_rnid [`SCARIV_LSU_WR_PORT];
  assign w_wr_data [`SCARIV_LSU_WR_PORT] = i_wr_data [`SCARIV_LSU_WR_PORT];

  // FPU move
  assign w_wr_valid[`SCARIV_FPU_MV_WR_PORT] = i_wr_valid[`SCARIV_FPU_MV_WR_PORT];
  assign w_wr_type [`SCARIV_FPU_MV_WR_PORT] = i_wr_type [`SCARIV_FPU_MV_WR_PORT];
  assign w_wr_rnid [`SCARIV_FPU_MV_WR_PORT] = i_wr_rnid [`SCARIV_FPU_MV_WR_PORT];
  assign w_wr_data [`SCARIV_FPU_MV_WR_PORT] = i_wr_data [`SCARIV_FPU_MV_WR_PORT];

  // FPU arithmetic
  assign w_wr_valid[`SCARIV_FPU_WR_PORT] = i_wr_valid[`SCARIV_FPU_WR_PORT];
  assign w_wr_type [`SCARIV_FPU_WR_PORT] = i_wr_type [`SCARIV_FPU_WR_PORT];
  assign w_wr_rnid [`SCARIV_FPU_WR_PORT] = i_wr_rnid [`SCARIV_FPU_WR_PORT];
  assign w_wr_data [`SCARIV_FPU_WR_PORT] = i_wr_data [`SCARIV_FPU_WR_PORT];

  // --------------------
  // Physical files
  // --------------------
  scariv_phy_registers #(
    .REG_TYPE (GPR)
  ) u_int_phy_registers (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_valid (w_wr_valid),
    .i_wr_type  (w_wr_type),
    .i_wr_rnid  (w_wr_rnid),
    .i_wr_data  (w_wr_data),
    .i_rd_rnid  (i_rd_rnid),
    .o_rd_data  (w_int_rd_data)
  );

  scariv_phy_registers #(
    .REG_TYPE (FPR)
  ) u_fp_phy_registers (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_valid (w_wr_valid),
    .i_wr_type  (w_wr_type),
    .i_wr_rnid  (w_wr_rnid),
    .i_wr_data  (w_wr_data),
    .i_rd_rnid  (i_rd_rnid),
    .o_rd_data  (w_fp_rd_data)
  );

  // --------------------
  // Read merge
  // --------------------
  scariv_regread_merge u_regread_merge (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_rd_valid    (i_rd_valid),
    .i_rd_type     (i_rd_type),
    .i_int_rd_data (w_int_rd_data),
    .i_fp_rd_data  (w_fp_rd_data),
    .o_rd_valid    (o_rd_valid),
    .o_rd_data     (o_rd_data)
  );

endmodule

// ==== include/scariv_macros.svh ====
// Register side configuration
// Widths, port counts and writeback port bases shared by RTL and testbench

`ifndef SCARIV_MACROS_SVH
`define SCARIV_MACROS_SVH

// --------------------
// Data path widths
// --------------------
`define SCARIV_XLEN     32
`define SCARIV_RNID_W   6   // 64 physical registers per file

// --------------------
// Port counts
// --------------------
`define SCARIV_WR_PORTS 4
`define SCARIV_RD_PORTS 4

// --------------------
// Writeback port bases
// --------------------
`define SCARIV_ALU_WR_PORT    0
`define SCARIV_LSU_WR_PORT    1
`define SCARIV_FPU_MV_WR_PORT 2   // FPU move, may target either file
`define SCARIV_FPU_WR_PORT    3

`endif

// ==== verification/scariv_regs_model.svh ====
// Reference model of the integer and FP register files
// Also holds the xorshift generator for the random stimulus

`ifndef SCARIV_REGS_MODEL_SVH
`define SCARIV_REGS_MODEL_SVH

reg_data_t   ref_int [1 << `SCARIV_RNID_W] = '{default: '0};
reg_data_t   ref_fp  [1 << `SCARIV_RNID_W] = '{default: '0};
logic [31:0] rng_state = 32'hafa2;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] next_random();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// Called in port order, so the highest port lands last
task automatic store_reference(input reg_type_t t, input rnid_t n, input reg_data_t d);
  if (t == FPR) begin
    ref_fp[n] = d;
  end else if (n != '0) begin  // Integer x0 stays zero
    ref_int[n] = d;
  end
endtask

function automatic reg_data_t expected_value(input reg_type_t t, input rnid_t n);
  if (t == FPR) begin
    return ref_fp[n];
  end
  return ref_int[n];
endfunction

`endif

// ==== verification/scariv_regs_tb.sv ====
// Register side testbench
// Random and directed writeback and read traffic, checked against a model

`include "scariv_macros.svh"

module scariv_regs_tb
  import scariv_reg_pkg::*;
  import scariv_port_pkg::*;
();

  localparam int NWR = `SCARIV_WR_PORTS;
  localparam int NRD = `SCARIV_RD_PORTS;
  localparam int TEST_CYCLES = 240;  // Reset plus all tests
  localparam int MARGIN = 100;

  logic      clk;
  logic      rst_n;
  wr_mask_t  wr_valid;
  reg_type_t wr_type [NWR];
  rnid_t     wr_rnid [NWR];
  reg_data_t wr_data [NWR];
  rd_mask_t  rd_valid;
  reg_type_t rd_type [NRD];
  rnid_t     rd_rnid [NRD];
  rd_mask_t  rd_valid_out;
  reg_data_t rd_data_out [NRD];

  // Stimulus for the next cycle
  wr_mask_t  nx_wr_valid;
  reg_type_t nx_wr_type [NWR];
  rnid_t     nx_wr_rnid [NWR];
  reg_data_t nx_wr_data [NWR];
  rd_mask_t  nx_rd_valid;
  reg_type_t nx_rd_type [NRD];
  rnid_t     nx_rd_rnid [NRD];

  rd_mask_t  exp_valid;
  reg_data_t exp_data [NRD];
  int        errors;
  int        checks;
  int        tests_run;
  int        tests_failed;
  int        test_err_start;
  string     test_name;

  `include "scariv_regs_model.svh"

  scariv_regs_top i_dut (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_wr_valid (wr_valid),
    .i_wr_type  (wr_type),
    .i_wr_rnid  (wr_rnid),
    .i_wr_data  (wr_data),
    .i_rd_valid (rd_valid),
    .i_rd_type  (rd_type),
    .i_rd_rnid  (rd_rnid),
    .o_rd_valid (rd_valid_out),
    .o_rd_data  (rd_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    #((TEST_CYCLES + MARGIN) * 40);
    $display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
    $display("Some tests failed");
    $finish;
  end

  task automatic post_write(input int p, input reg_type_t t, input rnid_t n, input reg_data_t d);
    nx_wr_valid[p] = 1'b1;
    nx_wr_type[p]  = t;
    nx_wr_rnid[p]  = n;
    nx_wr_data[p]  = d;
  endtask

  task automatic request_read(input int p, input reg_type_t t, input rnid_t n);
    nx_rd_valid[p] = 1'b1;
    nx_rd_type[p]  = t;
    nx_rd_rnid[p]  = n;
  endtask

  task automatic check_outputs();
    checks++;
    assert (rd_valid_out === exp_valid) else begin
      $display("MISMATCH o_rd_valid expected %h actual %h", exp_valid, rd_valid_out);
      errors++;
    end
    for (int p = 0; p < NRD; p++) begin
      if (exp_valid[p]) begin
        checks++;
        assert (rd_data_out[p] === exp_data[p]) else begin
          $display("MISMATCH o_rd_data[%0d] expected %h actual %h", p, exp_data[p],
                   rd_data_out[p]);
          errors++;
        end
      end
    end
  endtask

  // Check last cycle's reads, then drive the queued stimulus
  task automatic advance_cycle();
    @(posedge clk);
    #1;
    check_outputs();
    wr_valid = nx_wr_valid;
    rd_valid = nx_rd_valid;
    for (int p = 0; p < NWR; p++) begin
      wr_type[p] = nx_wr_type[p];
      wr_rnid[p] = nx_wr_rnid[p];
      wr_data[p] = nx_wr_data[p];
      if (nx_wr_valid[p]) store_reference(nx_wr_type[p], nx_wr_rnid[p], nx_wr_data[p]);
    end
    // Reads see the writes of the same edge
    for (int p = 0; p < NRD; p++) begin
      rd_type[p]  = nx_rd_type[p];
      rd_rnid[p]  = nx_rd_rnid[p];
      exp_data[p] = expected_value(nx_rd_type[p], nx_rd_rnid[p]);
    end
    exp_valid   = nx_rd_valid;
    nx_wr_valid = '0;
    nx_rd_valid = '0;
  endtask

  task automatic random_traffic_cycle();
    logic [31:0] r;
    for (int p = 0; p < NWR; p++) begin
      r = next_random();
      if (r[0]) post_write(p, reg_type_t'(r[1]), r[2] ? r[9:4] : {2'b00, r[7:4]}, next_random());
    end
    for (int p = 0; p < NRD; p++) begin
      r = next_random();
      if (r[0]) request_read(p, reg_type_t'(r[1]), r[2] ? r[9:4] : {2'b00, r[7:4]});
    end
    advance_cycle();
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = errors;
  endtask

  task automatic finish_test();
    repeat (2) advance_cycle();  // Drive queued stimulus, then check its reads
    tests_run++;
    if (errors != test_err_start) begin
      tests_failed++;
      $display("test %0d %s: FAIL", tests_run, test_name);
    end else begin
      $display("test %0d %s: ok", tests_run, test_name);
    end
  endtask

  initial begin
    logic [31:0] r;
    reg_data_t   d;
    rst_n = 1'b0;
    wr_valid = '0;
    rd_valid = '0;
    nx_wr_valid = '0;
    nx_rd_valid = '0;
    exp_valid = '0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int p = 0; p < NWR; p++) begin
      wr_type[p] = GPR;
      wr_rnid[p] = '0;
      wr_data[p] = '0;
      nx_wr_type[p] = GPR;
      nx_wr_rnid[p] = '0;
      nx_wr_data[p] = '0;
    end
    for (int p = 0; p < NRD; p++) begin
      rd_type[p] = GPR;
      rd_rnid[p] = '0;
      nx_rd_type[p] = GPR;
      nx_rd_rnid[p] = '0;
    end
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    start_test("reset state");
    repeat (3) advance_cycle();
    for (int i = 0; i < 16; i++) begin
      for (int p = 0; p < NRD; p++) begin
        r = next_random();
        request_read(p, reg_type_t'(r[0]), r[9:4]);
      end
      advance_cycle();
    end
    finish_test();

    start_test("random traffic");
    repeat (200) random_traffic_cycle();
    finish_test();

    start_test("register 0");
    d = next_random();
    post_write(`SCARIV_ALU_WR_PORT, GPR, '0, d);
    post_write(`SCARIV_FPU_WR_PORT, FPR, '0, ~d);
    request_read(0, GPR, '0);
    request_read(1, FPR, '0);
    advance_cycle();
    request_read(2, GPR, '0);
    request_read(3, FPR, '0);
    finish_test();

    start_test("write bypass");
    d = next_random();
    post_write(`SCARIV_LSU_WR_PORT, GPR, 6'd17, d);
    post_write(`SCARIV_FPU_MV_WR_PORT, FPR, 6'd17, ~d);
    request_read(2, GPR, 6'd17);  // Same edge as the writes
    request_read(3, FPR, 6'd17);
    finish_test();

    start_test("write priority");
    for (int p = 0; p < NWR; p++) post_write(p, GPR, 6'd33, next_random());
    advance_cycle();
    request_read(0, GPR, 6'd33);
    for (int p = 0; p < NWR - 1; p++) post_write(p, FPR, 6'd33, next_random());
    advance_cycle();
    request_read(1, FPR, 6'd33);
    finish_test();

    start_test("type separation");
    d = next_random();
    post_write(`SCARIV_ALU_WR_PORT, GPR, 6'd9, d);
    post_write(`SCARIV_FPU_WR_PORT, FPR, 6'd9, ~d);
    advance_cycle();
    request_read(0, GPR, 6'd9);
    request_read(1, FPR, 6'd9);
    finish_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
+incdir+verification
hw/scariv_reg_pkg.sv
hw/scariv_port_pkg.sv
hw/scariv_phy_registers.sv
hw/scariv_regread_merge.sv
hw/scariv_regs_top.sv
verification/scariv_regs_tb.sv
